//--- csrPkg.sv
package csrPkg;

  //////////////////////////////////////////////////
  // Basic widths
  //////////////////////////////////////////////////

  // One CSR value, RV32 only
  typedef logic [31:0] xlenWord;

  // 12-bit CSR address space
  typedef logic [11:0] csrAddr;

  // Access operation, encoded like funct3[1:0] of the CSR instructions
  typedef logic [1:0] csrOpCode;

  localparam csrOpCode csrOpWrite = 2'b01;
  localparam csrOpCode csrOpSet   = 2'b10;
  localparam csrOpCode csrOpClear = 2'b11;

  //////////////////////////////////////////////////
  // Machine-mode CSR addresses
  //////////////////////////////////////////////////

  // Identification, read-only by address bits 11:10
  localparam csrAddr addrMvendorid = 12'hF11;
  localparam csrAddr addrMarchid   = 12'hF12;
  localparam csrAddr addrMimpid    = 12'hF13;
  localparam csrAddr addrMhartid   = 12'hF14;

  // Trap setup
  localparam csrAddr addrMstatus = 12'h300;
  localparam csrAddr addrMisa    = 12'h301;
  localparam csrAddr addrMie     = 12'h304;
  localparam csrAddr addrMtvec   = 12'h305;

  localparam csrAddr addrMcountinhibit = 12'h320;

  // Trap handling
  localparam csrAddr addrMscratch = 12'h340;
  localparam csrAddr addrMepc     = 12'h341;
  localparam csrAddr addrMcause   = 12'h342;
  localparam csrAddr addrMtval    = 12'h343;
  localparam csrAddr addrMip      = 12'h344;

  // Protection, further entries follow at consecutive addresses
  localparam csrAddr addrPmpcfg0  = 12'h3A0;
  localparam csrAddr addrPmpaddr0 = 12'h3B0;

  // Counters, low and high halves
  localparam csrAddr addrMcycle    = 12'hB00;
  localparam csrAddr addrMinstret  = 12'hB02;
  localparam csrAddr addrMcycleh   = 12'hB80;
  localparam csrAddr addrMinstreth = 12'hB82;

  //////////////////////////////////////////////////
  // Hardwired identification values
  //////////////////////////////////////////////////

  // MXL = 01 (RV32), extensions I (bit 8) and M (bit 12)
  localparam xlenWord misaValue = 32'h4000_1100;

  // Implementation number of the pipelined core
  localparam xlenWord mimpidValue = 32'h0000_0100;

endpackage

//--- csrMachine.sv
`timescale 1ns/1ps

module csrMachine #(
  parameter int pmpEntries = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     writeEn,
  input  csrPkg::csrAddr           csrAddr,
  input  csrPkg::xlenWord          writeVal,
  input  logic                     trap,
  input  csrPkg::xlenWord          trapCause,
  input  csrPkg::xlenWord          trapPc,
  input  csrPkg::xlenWord          trapVal,
  input  logic                     mret,
  input  logic                     irqSoftware,
  input  logic                     irqTimer,
  input  logic                     irqExternal,
  output logic                     machineHit,
  output csrPkg::xlenWord          machineReadVal,
  output csrPkg::xlenWord          mtvec,
  output csrPkg::xlenWord          mepc,
  output logic                     interruptPending,
  output logic                     inhibitCycle,
  output logic                     inhibitInstret,
  output logic [pmpEntries*8-1:0]  pmpCfgFlat,
  output logic [pmpEntries*30-1:0] pmpAddrFlat
);

  // Four 8-bit entries per pmpcfg register
  localparam int cfgRegs = (pmpEntries + 3) / 4;

  // Only MSIE, MTIE and MEIE exist
  localparam csrPkg::xlenWord mieMask = 32'h0000_0888;

  logic            mstatusMie;
  logic            mstatusMpie;
  csrPkg::xlenWord mstatus;
  csrPkg::xlenWord mieReg;
  csrPkg::xlenWord mip;
  csrPkg::xlenWord mscratch;
  csrPkg::xlenWord mcause;
  csrPkg::xlenWord mtval;

  logic writeMstatus;
  logic writeMie;
  logic writeMtvec;
  logic writeMscratch;
  logic writeMepc;
  logic writeMcause;
  logic writeMtval;
  logic writeInhibit;

  logic [7:0]            pmpCfg [pmpEntries];
  logic [29:0]           pmpAddr [pmpEntries];
  logic [pmpEntries-1:0] pmpAddrSel;
  logic [pmpEntries-1:0] cfgLocked;
  logic [pmpEntries-1:0] addrLocked;
  logic [cfgRegs-1:0]    pmpCfgSel;
  logic [cfgRegs*32-1:0] cfgPadded;

  logic            pmpHit;
  logic            regHit;
  csrPkg::xlenWord pmpReadVal;
  csrPkg::xlenWord regReadVal;

  //////////////////////////////////////////////////
  // Write strobes
  //////////////////////////////////////////////////

  // writeEn already excludes illegal and no-op accesses
  assign writeMstatus  = writeEn & (csrAddr == csrPkg::addrMstatus);
  assign writeMie      = writeEn & (csrAddr == csrPkg::addrMie);
  assign writeMtvec    = writeEn & (csrAddr == csrPkg::addrMtvec);
  assign writeMscratch = writeEn & (csrAddr == csrPkg::addrMscratch);
  assign writeMepc     = writeEn & (csrAddr == csrPkg::addrMepc);
  assign writeMcause   = writeEn & (csrAddr == csrPkg::addrMcause);
  assign writeMtval    = writeEn & (csrAddr == csrPkg::addrMtval);
  assign writeInhibit  = writeEn & (csrAddr == csrPkg::addrMcountinhibit);

  //////////////////////////////////////////////////
  // Status and trap registers
  //////////////////////////////////////////////////

  // Trap wins over mret, mret wins over a CSR write
  always_ff @(posedge clk) begin
    if (reset) begin
      mstatusMie  <= 1'b0;
      mstatusMpie <= 1'b0;
    end else if (trap) begin
      mstatusMpie <= mstatusMie;
      mstatusMie  <= 1'b0;
    end else if (mret) begin
      mstatusMie  <= mstatusMpie;
      mstatusMpie <= 1'b1;
    end else if (writeMstatus) begin
      mstatusMie  <= writeVal[3];
      mstatusMpie <= writeVal[7];
    end
  end

  // IALIGN is 32, so mepc bits 1:0 stay zero
  always_ff @(posedge clk) begin
    if (reset) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (trap) begin
      mepc   <= {trapPc[31:2], 2'b00};
      mcause <= trapCause;
      mtval  <= trapVal;
    end else begin
      if (writeMepc) begin
        mepc <= {writeVal[31:2], 2'b00};
      end
      if (writeMcause) begin
        mcause <= writeVal;
      end
      if (writeMtval) begin
        mtval <= writeVal;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mieReg         <= '0;
      mtvec          <= '0;
      mscratch       <= '0;
      inhibitCycle   <= 1'b0;
      inhibitInstret <= 1'b0;
    end else begin
      if (writeMie) begin
        mieReg <= writeVal & mieMask;
      end
      // Mode bit 1 is reserved, only direct and vectored remain
      if (writeMtvec) begin
        mtvec <= {writeVal[31:2], 1'b0, writeVal[0]};
      end
      if (writeMscratch) begin
        mscratch <= writeVal;
      end
      // CY is bit 0, IR is bit 2
      if (writeInhibit) begin
        inhibitCycle   <= writeVal[0];
        inhibitInstret <= writeVal[2];
      end
    end
  end

  // MPP reads as machine mode permanently
  assign mstatus = {19'b0, 2'b11, 3'b0, mstatusMpie, 3'b0, mstatusMie, 3'b0};

  // Pending bits come straight from the interrupt lines
  assign mip = {20'b0, irqExternal, 3'b0, irqTimer, 3'b0, irqSoftware, 3'b0};

  assign interruptPending = mstatusMie & (|(mip & mieReg));

  //////////////////////////////////////////////////
  // Physical memory protection
  //////////////////////////////////////////////////

  for (genvar j = 0; j < cfgRegs; j++) begin : gCfgSel
    assign pmpCfgSel[j] = csrAddr == csrPkg::csrAddr'(csrPkg::addrPmpcfg0 + j);
  end

  for (genvar i = 0; i < pmpEntries; i++) begin : gPmpEntry
    assign pmpAddrSel[i] = csrAddr == csrPkg::csrAddr'(csrPkg::addrPmpaddr0 + i);
    assign cfgLocked[i]  = pmpCfg[i][7];

    // A locked TOR entry also freezes the address below it
    if (i == pmpEntries - 1) begin : gLast
      assign addrLocked[i] = pmpCfg[i][7];
    end else begin : gTor
      assign addrLocked[i] = pmpCfg[i][7] | (pmpCfg[i+1][7] & (pmpCfg[i+1][4:3] == 2'b01));
    end

    // Locked fields silently drop the write
    always_ff @(posedge clk) begin
      if (reset) begin
        pmpCfg[i]  <= '0;
        pmpAddr[i] <= '0;
      end else begin
        if (writeEn & pmpCfgSel[i/4] & ~cfgLocked[i]) begin
          pmpCfg[i] <= writeVal[(i%4)*8 +: 8];
        end
        if (writeEn & pmpAddrSel[i] & ~addrLocked[i]) begin
          pmpAddr[i] <= writeVal[29:0];
        end
      end
    end

    assign pmpCfgFlat[i*8 +: 8]    = pmpCfg[i];
    assign pmpAddrFlat[i*30 +: 30] = pmpAddr[i];
  end

  // Missing entries of the last pmpcfg register read as zero
  assign cfgPadded = (cfgRegs * 32)'(pmpCfgFlat);

  always_comb begin
    pmpReadVal = '0;
    for (int i = 0; i < pmpEntries; i++) begin
      if (pmpAddrSel[i]) begin
        pmpReadVal = pmpReadVal | {2'b00, pmpAddr[i]};
      end
    end
    for (int j = 0; j < cfgRegs; j++) begin
      if (pmpCfgSel[j]) begin
        pmpReadVal = pmpReadVal | cfgPadded[j*32 +: 32];
      end
    end
  end

  assign pmpHit = (|pmpAddrSel) | (|pmpCfgSel);

  //////////////////////////////////////////////////
  // Read decode
  //////////////////////////////////////////////////

  always_comb begin
    regHit     = 1'b1;
    regReadVal = '0;
    case (csrAddr)
      csrPkg::addrMvendorid:     regReadVal = '0;
      csrPkg::addrMarchid:       regReadVal = '0;
      csrPkg::addrMimpid:        regReadVal = csrPkg::mimpidValue;
      csrPkg::addrMhartid:       regReadVal = '0;  // single hart
      csrPkg::addrMstatus:       regReadVal = mstatus;
      csrPkg::addrMisa:          regReadVal = csrPkg::misaValue;
      csrPkg::addrMie:           regReadVal = mieReg;
      csrPkg::addrMtvec:         regReadVal = mtvec;
      csrPkg::addrMcountinhibit: regReadVal = {29'b0, inhibitInstret, 1'b0, inhibitCycle};
      csrPkg::addrMscratch:      regReadVal = mscratch;
      csrPkg::addrMepc:          regReadVal = mepc;
      csrPkg::addrMcause:        regReadVal = mcause;
      csrPkg::addrMtval:         regReadVal = mtval;
      csrPkg::addrMip:           regReadVal = mip;
      default:                   regHit = 1'b0;
    endcase
  end

  // PMP addresses never overlap the case above
  assign machineHit     = regHit | pmpHit;
  assign machineReadVal = regReadVal | pmpReadVal;

endmodule

//--- csrCounters.sv
`timescale 1ns/1ps

module csrCounters (
  input  logic            clk,
  input  logic            reset,
  input  logic            writeEn,
  input  csrPkg::csrAddr  csrAddr,
  input  csrPkg::xlenWord writeVal,
  input  logic            instrRetired,
  input  logic            inhibitCycle,
  input  logic            inhibitInstret,
  output logic            counterHit,
  output csrPkg::xlenWord counterReadVal
);

  // Index 0 is mcycle, index 1 is minstret
  logic [63:0] count [2];
  logic [1:0]  lowSel;
  logic [1:0]  highSel;
  logic [1:0]  countEnable;

  //////////////////////////////////////////////////
  // Increment conditions
  //////////////////////////////////////////////////

  // mcycle runs freely unless inhibited
  assign countEnable[0] = ~inhibitCycle;

  // minstret counts retire pulses
  assign countEnable[1] = instrRetired & ~inhibitInstret;

  //////////////////////////////////////////////////
  // Counter registers
  //////////////////////////////////////////////////

  for (genvar c = 0; c < 2; c++) begin : gCounter
    localparam csrPkg::csrAddr lowAddr =
      (c == 0) ? csrPkg::addrMcycle : csrPkg::addrMinstret;
    localparam csrPkg::csrAddr highAddr =
      (c == 0) ? csrPkg::addrMcycleh : csrPkg::addrMinstreth;

    assign lowSel[c]  = csrAddr == lowAddr;
    assign highSel[c] = csrAddr == highAddr;

    // A write replaces one half and skips this cycle's increment
    always_ff @(posedge clk) begin
      if (reset) begin
        count[c] <= '0;
      end else if (writeEn & lowSel[c]) begin
        count[c][31:0] <= writeVal;
      end else if (writeEn & highSel[c]) begin
        count[c][63:32] <= writeVal;
      end else if (countEnable[c]) begin
        count[c] <= count[c] + 64'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read decode
  //////////////////////////////////////////////////

  always_comb begin
    counterReadVal = '0;
    for (int c = 0; c < 2; c++) begin
      if (lowSel[c]) begin
        counterReadVal = count[c][31:0];
      end
      if (highSel[c]) begin
        counterReadVal = count[c][63:32];
      end
    end
  end

  assign counterHit = (|lowSel) | (|highSel);

endmodule

//--- csrAccess.sv
`timescale 1ns/1ps

module csrAccess (
  input  logic             csrValid,
  input  csrPkg::csrOpCode csrOp,
  input  csrPkg::csrAddr   csrAddr,
  input  csrPkg::xlenWord  csrSrc,
  input  logic             machineHit,
  input  csrPkg::xlenWord  machineReadVal,
  input  logic             counterHit,
  input  csrPkg::xlenWord  counterReadVal,
  output csrPkg::xlenWord  csrReadVal,
  output logic             csrIllegal,
  output logic             writeEn,
  output csrPkg::xlenWord  writeVal
);

  logic anyHit;
  logic readOnly;
  logic writeAttempt;

  //////////////////////////////////////////////////
  // Read data merge
  //////////////////////////////////////////////////

  assign anyHit = machineHit | counterHit;

  // Blocks decode disjoint ranges, a miss reads zero
  always_comb begin
    if (machineHit) begin
      csrReadVal = machineReadVal;
    end else if (counterHit) begin
      csrReadVal = counterReadVal;
    end else begin
      csrReadVal = '0;
    end
  end

  //////////////////////////////////////////////////
  // Write value
  //////////////////////////////////////////////////

  // Set and clear with a zero source are pure reads
  always_comb begin
    case (csrOp)
      csrPkg::csrOpWrite: begin
        writeAttempt = 1'b1;
        writeVal     = csrSrc;
      end
      csrPkg::csrOpSet: begin
        writeAttempt = csrSrc != '0;
        writeVal     = csrReadVal | csrSrc;
      end
      csrPkg::csrOpClear: begin
        writeAttempt = csrSrc != '0;
        writeVal     = csrReadVal & ~csrSrc;
      end
      default: begin
        // Unused encoding behaves as a read
        writeAttempt = 1'b0;
        writeVal     = csrReadVal;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Legality
  //////////////////////////////////////////////////

  // Address bits 11:10 equal to 11 mark a read-only CSR
  assign readOnly = csrAddr[11:10] == 2'b11;

  assign csrIllegal = csrValid & (~anyHit | (writeAttempt & readOnly));

  // Illegal accesses leave all state untouched
  assign writeEn = csrValid & writeAttempt & ~csrIllegal;

endmodule

//--- csrUnit.sv
`timescale 1ns/1ps

module csrUnit #(
  parameter int pmpEntries = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  // Access port from the memory stage
  input  logic                     csrValid,
  input  csrPkg::csrOpCode         csrOp,
  input  csrPkg::csrAddr           csrAddr,
  input  csrPkg::xlenWord          csrSrc,
  output csrPkg::xlenWord          csrReadVal,
  output logic                     csrIllegal,
  // Trap and return
  input  logic                     trap,
  input  csrPkg::xlenWord          trapCause,
  input  csrPkg::xlenWord          trapPc,
  input  csrPkg::xlenWord          trapVal,
  input  logic                     mret,
  // Interrupt lines and retire pulse
  input  logic                     irqSoftware,
  input  logic                     irqTimer,
  input  logic                     irqExternal,
  input  logic                     instrRetired,
  // State seen by the pipeline
  output csrPkg::xlenWord          mtvec,
  output csrPkg::xlenWord          mepc,
  output logic                     interruptPending,
  output logic [pmpEntries*8-1:0]  pmpCfgFlat,
  output logic [pmpEntries*30-1:0] pmpAddrFlat
);

  //////////////////////////////////////////////////
  // Internal nets, named to match the block ports
  //////////////////////////////////////////////////

  logic            machineHit;
  csrPkg::xlenWord machineReadVal;
  logic            counterHit;
  csrPkg::xlenWord counterReadVal;
  logic            writeEn;
  csrPkg::xlenWord writeVal;
  logic            inhibitCycle;
  logic            inhibitInstret;

  csrMachine #(.pmpEntries(pmpEntries)) machineInst (.*);

  csrCounters countersInst (.*);

  // Read merge, legality and write value
  csrAccess accessInst (.*);

endmodule

//--- tb_csrUnit.sv
`timescale 1ns/1ps

module tb_csrUnit;

  localparam int clkPeriod   = 20;
  localparam int resetCycles = 5;
  localparam int pmpEntries  = 4;
  localparam int randOps     = 200;

  // Rough cycle cost of all tests for the watchdog
  localparam int budgetCycles = resetCycles + 60 + 3 * randOps + 40 + 30 + 90;

  logic                     clk;
  logic                     reset;
  logic                     csrValid;
  csrPkg::csrOpCode         csrOp;
  csrPkg::csrAddr           csrAddr;
  csrPkg::xlenWord          csrSrc;
  csrPkg::xlenWord          csrReadVal;
  logic                     csrIllegal;
  logic                     trap;
  csrPkg::xlenWord          trapCause;
  csrPkg::xlenWord          trapPc;
  csrPkg::xlenWord          trapVal;
  logic                     mret;
  logic                     irqSoftware;
  logic                     irqTimer;
  logic                     irqExternal;
  logic                     instrRetired;
  csrPkg::xlenWord          mtvec;
  csrPkg::xlenWord          mepc;
  logic                     interruptPending;
  logic [pmpEntries*8-1:0]  pmpCfgFlat;
  logic [pmpEntries*30-1:0] pmpAddrFlat;

  // Shadow state of the reference model
  logic        modelReady;
  logic        shMie;
  logic        shMpie;
  logic [31:0] shMieReg;
  logic [31:0] shMtvec;
  logic [31:0] shMscratch;
  logic [31:0] shMepc;
  logic [31:0] shMcause;
  logic [31:0] shMtval;
  logic        shInhCycle;
  logic        shInhInstret;
  logic [7:0]  shPmpCfg [pmpEntries];
  logic [29:0] shPmpAddr [pmpEntries];
  logic [63:0] shCycle;
  logic [63:0] shInstret;

  logic [15:0] lfsrState;
  int          checkCount;
  int          errorCount;
  int          testStart;

  csrUnit #(.pmpEntries(pmpEntries)) dut_i (.*);

  //////////////////////////////////////////////////
  // Clock, reset and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever begin
      #(clkPeriod / 2) clk = ~clk;
    end
  end

  initial begin
    #(budgetCycles * clkPeriod * 2 + 1000);
    $display("Watchdog expired before the tests completed");
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // One LFSR step per bit taken
  task automatic randBits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsrState = lfsrNext(lfsrState);
      val = {val[30:0], lfsrState[0]};
    end
  endtask

  task automatic checkVal(input string name, input logic [63:0] got,
                          input logic [63:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic reportTest(input string name);
    if (errorCount == testStart) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errorCount - testStart);
    end
    testStart = errorCount;
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // True for a write or for set and clear with a nonzero source
  function automatic logic wantsWrite(input logic [1:0] op, input logic [31:0] src);
    return (op == 2'b01) || ((op == 2'b10 || op == 2'b11) && src != 32'h0);
  endfunction

  // Expected read value of one address from the shadow state
  function automatic logic [31:0] expectedRead(input logic [11:0] addr, output logic hit);
    logic [31:0] v;
    hit = 1'b1;
    v = 32'h0;
    case (addr)
      12'hF11, 12'hF12, 12'hF14: v = 32'h0;
      12'hF13: v = 32'h0000_0100;
      // MPP fixed at 11 in bits 12:11
      12'h300: v = 32'h0000_1800 | {24'h0, shMpie, 3'b0, shMie, 3'b0};
      // MXL 01 with I and M
      12'h301: v = 32'h4000_1100;
      12'h304: v = shMieReg;
      12'h305: v = shMtvec;
      12'h320: v = {29'h0, shInhInstret, 1'b0, shInhCycle};
      12'h340: v = shMscratch;
      12'h341: v = shMepc;
      12'h342: v = shMcause;
      12'h343: v = shMtval;
      12'h344: v = {20'h0, irqExternal, 3'b0, irqTimer, 3'b0, irqSoftware, 3'b0};
      12'h3A0: v = {shPmpCfg[3], shPmpCfg[2], shPmpCfg[1], shPmpCfg[0]};
      12'h3B0, 12'h3B1, 12'h3B2, 12'h3B3: v = {2'b00, shPmpAddr[addr[1:0]]};
      12'hB00: v = shCycle[31:0];
      12'hB80: v = shCycle[63:32];
      12'hB02: v = shInstret[31:0];
      12'hB82: v = shInstret[63:32];
      default: hit = 1'b0;
    endcase
    return v;
  endfunction

  task automatic resetShadow();
    shMie        = 1'b0;
    shMpie       = 1'b0;
    shMieReg     = '0;
    shMtvec      = '0;
    shMscratch   = '0;
    shMepc       = '0;
    shMcause     = '0;
    shMtval      = '0;
    shInhCycle   = 1'b0;
    shInhInstret = 1'b0;
    shCycle      = '0;
    shInstret    = '0;
    for (int i = 0; i < pmpEntries; i++) begin
      shPmpCfg[i]  = '0;
      shPmpAddr[i] = '0;
    end
  endtask

  // Shadow state after the coming clock edge
  task automatic advanceModel(input logic [31:0] rd, input logic illegal);
    logic [31:0]           wv;
    logic                  we;
    logic [pmpEntries-1:0] addrLk;
    wv = csrSrc;
    if (csrOp == 2'b10) begin
      wv = rd | csrSrc;
    end else if (csrOp == 2'b11) begin
      wv = rd & ~csrSrc;
    end
    we = csrValid & wantsWrite(csrOp, csrSrc) & ~illegal;
    // Lock state before this edge
    for (int i = 0; i < pmpEntries; i++) begin
      addrLk[i] = shPmpCfg[i][7];
      if (i < pmpEntries - 1) begin
        addrLk[i] = addrLk[i] | (shPmpCfg[i+1][7] & (shPmpCfg[i+1][4:3] == 2'b01));
      end
    end

    // Trap before mret before a CSR write
    if (trap) begin
      shMpie   = shMie;
      shMie    = 1'b0;
      shMepc   = trapPc & 32'hFFFF_FFFC;
      shMcause = trapCause;
      shMtval  = trapVal;
    end else begin
      if (mret) begin
        shMie  = shMpie;
        shMpie = 1'b1;
      end else if (we && csrAddr == 12'h300) begin
        shMie  = wv[3];
        shMpie = wv[7];
      end
      if (we && csrAddr == 12'h341) begin
        shMepc = wv & 32'hFFFF_FFFC;
      end
      if (we && csrAddr == 12'h342) begin
        shMcause = wv;
      end
      if (we && csrAddr == 12'h343) begin
        shMtval = wv;
      end
    end
    if (we && csrAddr == 12'h304) begin
      shMieReg = wv & 32'h0000_0888;
    end
    if (we && csrAddr == 12'h305) begin
      shMtvec = wv & 32'hFFFF_FFFD;
    end
    if (we && csrAddr == 12'h340) begin
      shMscratch = wv;
    end

    // Counters see the inhibit bits from before the edge
    if (we && csrAddr == 12'hB00) begin
      shCycle[31:0] = wv;
    end else if (we && csrAddr == 12'hB80) begin
      shCycle[63:32] = wv;
    end else if (!shInhCycle) begin
      shCycle = shCycle + 64'd1;
    end
    if (we && csrAddr == 12'hB02) begin
      shInstret[31:0] = wv;
    end else if (we && csrAddr == 12'hB82) begin
      shInstret[63:32] = wv;
    end else if (instrRetired && !shInhInstret) begin
      shInstret = shInstret + 64'd1;
    end
    if (we && csrAddr == 12'h320) begin
      shInhCycle   = wv[0];
      shInhInstret = wv[2];
    end

    // Locked entries drop the write
    for (int i = 0; i < pmpEntries; i++) begin
      if (we && csrAddr == 12'h3A0 && !shPmpCfg[i][7]) begin
        shPmpCfg[i] = wv[i*8 +: 8];
      end
      if (we && csrAddr == (12'h3B0 + 12'(i)) && !addrLk[i]) begin
        shPmpAddr[i] = wv[29:0];
      end
    end
  endtask

  // Compare at the falling edge where outputs are stable
  always @(negedge clk) begin : compareProc
    logic [31:0] rd;
    logic        hit;
    logic        illegal;
    logic        pending;
    if (reset) begin
      resetShadow();
      modelReady = 1'b1;
    end else if (modelReady) begin
      rd = expectedRead(csrAddr, hit);
      illegal = csrValid & (~hit | (wantsWrite(csrOp, csrSrc) & (csrAddr[11:10] == 2'b11)));
      if (csrValid) begin
        checkVal("csrReadVal", {32'h0, csrReadVal}, {32'h0, rd});
        checkVal("csrIllegal", {63'h0, csrIllegal}, {63'h0, illegal});
      end
      pending = shMie & (|({20'h0, irqExternal, 3'b0, irqTimer, 3'b0, irqSoftware, 3'b0}
                           & shMieReg));
      checkVal("interruptPending", {63'h0, interruptPending}, {63'h0, pending});
      checkVal("mtvec", {32'h0, mtvec}, {32'h0, shMtvec});
      checkVal("mepc", {32'h0, mepc}, {32'h0, shMepc});
      for (int i = 0; i < pmpEntries; i++) begin
        checkVal("pmpCfgFlat", {56'h0, pmpCfgFlat[i*8 +: 8]}, {56'h0, shPmpCfg[i]});
        checkVal("pmpAddrFlat", {34'h0, pmpAddrFlat[i*30 +: 30]}, {34'h0, shPmpAddr[i]});
      end
      advanceModel(rd, illegal);
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks driven at the rising edge
  //////////////////////////////////////////////////

  task automatic putInputs(input logic valid, input logic [1:0] op,
                           input logic [11:0] addr, input logic [31:0] src,
                           input logic mretV, input logic retire);
    csrValid     <= valid;
    csrOp        <= op;
    csrAddr      <= addr;
    csrSrc       <= src;
    trap         <= 1'b0;
    mret         <= mretV;
    instrRetired <= retire;
  endtask

  // One access cycle with read data sampled mid-cycle
  task automatic access(input logic [1:0] op, input logic [11:0] addr,
                        input logic [31:0] src, output logic [31:0] rd);
    @(posedge clk);
    putInputs(1'b1, op, addr, src, 1'b0, 1'b0);
    @(negedge clk);
    rd = csrReadVal;
  endtask

  task automatic idle(input int n, input logic retire);
    repeat (n) begin
      @(posedge clk);
      putInputs(1'b0, 2'b01, 12'h0, 32'h0, 1'b0, retire);
    end
  endtask

  task automatic raiseTrap(input logic [31:0] cause, input logic [31:0] pc,
                           input logic [31:0] val);
    @(posedge clk);
    putInputs(1'b0, 2'b01, 12'h0, 32'h0, 1'b0, 1'b0);
    trap      <= 1'b1;
    trapCause <= cause;
    trapPc    <= pc;
    trapVal   <= val;
  endtask

  task automatic setIrq(input logic sw, input logic tm, input logic ex);
    @(posedge clk);
    putInputs(1'b0, 2'b01, 12'h0, 32'h0, 1'b0, 1'b0);
    irqSoftware <= sw;
    irqTimer    <= tm;
    irqExternal <= ex;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : mainProc
    logic [11:0] idAddrs [4];
    logic [11:0] rwAddrs [4];
    logic [31:0] rd;
    logic [31:0] first;
    logic [31:0] r;
    logic [31:0] src;
    logic [1:0]  op;
    csrValid     = 1'b0;
    csrOp        = 2'b01;
    csrAddr      = '0;
    csrSrc       = '0;
    trap         = 1'b0;
    trapCause    = '0;
    trapPc       = '0;
    trapVal      = '0;
    mret         = 1'b0;
    irqSoftware  = 1'b0;
    irqTimer     = 1'b0;
    irqExternal  = 1'b0;
    instrRetired = 1'b0;
    reset        = 1'b1;
    modelReady   = 1'b0;
    lfsrState    = 16'd18753;
    checkCount   = 0;
    errorCount   = 0;
    testStart    = 0;
    idAddrs = '{12'hF11, 12'hF12, 12'hF13, 12'hF14};
    rwAddrs = '{12'h340, 12'h305, 12'h304, 12'h342};

    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
    idle(2, 1'b0);

    // Test 1 covers reset values, ID registers, read-only writes and unknown addresses
    for (int i = 0; i < 4; i++) begin
      access(2'b10, idAddrs[i], 32'h0, rd);
      access(2'b01, idAddrs[i], 32'hFFFF_FFFF, rd);
    end
    access(2'b10, 12'hF13, 32'h0, rd);
    checkVal("mimpid", {32'h0, rd}, 64'h100);
    access(2'b10, 12'h301, 32'h0, rd);
    access(2'b10, 12'h300, 32'h0, rd);
    access(2'b10, 12'h344, 32'h0, rd);
    access(2'b10, 12'h3A0, 32'h0, rd);
    access(2'b10, 12'hB80, 32'h0, rd);
    access(2'b10, 12'h7C0, 32'h0, rd);
    access(2'b01, 12'h123, 32'h5555_AAAA, rd);
    idle(1, 1'b0);
    reportTest("reset and identification");

    // Test 2 runs random write, set and clear with 1 in 8 sources zero
    for (int n = 0; n < randOps; n++) begin
      randBits(2, r);
      op = (r[1:0] == 2'b00) ? 2'b01 : r[1:0];
      randBits(2, r);
      randBits(3, first);
      randBits(32, src);
      if (first[2:0] == 3'b000) begin
        src = 32'h0;
      end
      access(op, rwAddrs[r[1:0]], src, rd);
      access(2'b10, rwAddrs[r[1:0]], 32'h0, rd);
    end
    idle(1, 1'b0);
    reportTest("random read-modify-write");

    // Test 3 covers interrupt enable, trap and mret
    access(2'b01, 12'h304, 32'hFFFF_FFFF, rd);
    setIrq(1'b0, 1'b1, 1'b0);
    access(2'b10, 12'h300, 32'h0000_0008, rd);
    idle(1, 1'b0);
    @(negedge clk);
    checkVal("interruptPending", {63'h0, interruptPending}, 64'h1);
    access(2'b01, 12'h305, 32'h8000_0103, rd);
    raiseTrap(32'h8000_0007, 32'h0000_1236, 32'h0000_DEAD);
    idle(1, 1'b0);
    @(negedge clk);
    checkVal("mepc", {32'h0, mepc}, 64'h1234);
    access(2'b10, 12'h342, 32'h0, rd);
    access(2'b10, 12'h343, 32'h0, rd);
    access(2'b10, 12'h300, 32'h0, rd);
    @(posedge clk);
    putInputs(1'b0, 2'b01, 12'h0, 32'h0, 1'b1, 1'b0);
    access(2'b10, 12'h300, 32'h0, rd);
    setIrq(1'b1, 1'b0, 1'b1);
    idle(2, 1'b0);
    setIrq(1'b0, 1'b0, 1'b0);
    idle(1, 1'b0);
    reportTest("trap and mret");

    // Test 4 locks entry 1 in TOR mode to freeze pmpaddr0 and pmpaddr1
    access(2'b01, 12'h3B0, 32'h0000_0100, rd);
    access(2'b01, 12'h3B1, 32'h0000_0200, rd);
    access(2'b01, 12'h3A0, 32'h0000_8801, rd);
    access(2'b01, 12'h3B0, 32'h0000_0AAA, rd);
    access(2'b01, 12'h3B1, 32'h0000_0BBB, rd);
    access(2'b01, 12'h3B2, 32'h0000_0CCC, rd);
    access(2'b01, 12'h3A0, 32'h0000_0000, rd);
    access(2'b10, 12'h3B0, 32'h0, rd);
    checkVal("pmpaddr0", {32'h0, rd}, 64'h100);
    access(2'b10, 12'h3B1, 32'h0, rd);
    checkVal("pmpaddr1", {32'h0, rd}, 64'h200);
    access(2'b10, 12'h3A0, 32'h0, rd);
    checkVal("pmpcfg0", {32'h0, rd}, 64'h8800);
    idle(1, 1'b0);
    reportTest("protection locking");

    // Test 5 covers the counters
    access(2'b10, 12'hB00, 32'h0, first);
    idle(10, 1'b0);
    access(2'b10, 12'hB00, 32'h0, rd);
    checkVal("mcycle delta", {32'h0, rd - first}, 64'd11);
    access(2'b10, 12'hB02, 32'h0, first);
    idle(7, 1'b1);
    access(2'b10, 12'hB02, 32'h0, rd);
    checkVal("minstret delta", {32'h0, rd - first}, 64'd7);
    access(2'b01, 12'h320, 32'h0000_0005, rd);
    access(2'b10, 12'hB00, 32'h0, first);
    access(2'b10, 12'hB02, 32'h0, r);
    idle(5, 1'b1);
    access(2'b10, 12'hB00, 32'h0, rd);
    checkVal("inhibited mcycle", {32'h0, rd}, {32'h0, first});
    access(2'b10, 12'hB02, 32'h0, rd);
    checkVal("inhibited minstret", {32'h0, rd}, {32'h0, r});
    access(2'b11, 12'h320, 32'h0000_0005, rd);
    access(2'b01, 12'hB80, 32'h1234_5678, rd);
    access(2'b01, 12'hB02, 32'hCAFE_0000, rd);
    access(2'b10, 12'hB80, 32'h0, rd);
    checkVal("mcycleh", {32'h0, rd}, 64'h1234_5678);
    access(2'b10, 12'hB02, 32'h0, rd);
    checkVal("minstret", {32'h0, rd}, 64'hCAFE_0000);
    idle(2, 1'b0);
    reportTest("counters");

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- csrUnit.f
csrPkg.sv
csrMachine.sv
csrCounters.sv
csrAccess.sv
csrUnit.sv
tb_csrUnit.sv

//--- build.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_csrUnit -f csrUnit.f -o simCsrUnit \
  > build.log 2>&1 \
  && ./obj_dir/simCsrUnit > sim.log 2>&1 \
  || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "TB PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
